// ==== include/versat_dp_params.svh ====
`ifndef VERSAT_DP_PARAMS_SVH
`define VERSAT_DP_PARAMS_SVH

// data word width
`define DATA_W 32

// bus slots: in_a, in_b, alu, shifter
`define N_SLOTS 4

// slot select width
`define N_W 2

// function code widths
`define ALU_FNS_W 3
`define BS_FNS_W 2

// alu config, msb down: sel a, sel b, fns
`define ALU_CONF_BITS (2*`N_W + `ALU_FNS_W)

// shifter config, msb down: sel data, sel shift, fns
`define BS_CONF_BITS (2*`N_W + `BS_FNS_W)

// configuration write data, wide enough for either unit
`define CONF_W 8

// configuration addresses
`define CONF_ADDR_ALU 1'b0
`define CONF_ADDR_BS 1'b1

`endif

// ==== src/versat_dp_pkg.sv ====
`include "versat_dp_params.svh"

package versat_dp_pkg;

   // one data word
   typedef logic [`DATA_W-1:0] data_t;

   // whole data bus, slot 0 in the low bits
   typedef logic [`N_SLOTS*`DATA_W-1:0] bus_t;

   // bus slot select
   typedef logic [`N_W-1:0] sel_t;

   // function codes
   typedef logic [`ALU_FNS_W-1:0] alu_fns_t;
   typedef logic [`BS_FNS_W-1:0] bs_fns_t;

   // alu functions, codes 6 and 7 fall back to pass
   localparam alu_fns_t ALU_ADD = 3'd0;
   localparam alu_fns_t ALU_SUB = 3'd1;
   localparam alu_fns_t ALU_AND = 3'd2;
   localparam alu_fns_t ALU_OR = 3'd3;
   localparam alu_fns_t ALU_XOR = 3'd4;
   localparam alu_fns_t ALU_PASS = 3'd5;

   // shifter functions
   localparam bs_fns_t BS_SHR_A = 2'd0;
   localparam bs_fns_t BS_SHR_L = 2'd1;
   localparam bs_fns_t BS_SHL = 2'd2;
   localparam bs_fns_t BS_PASS = 2'd3;

   // shift amount taken from the low bits of the shift operand
   localparam int SHIFT_AMT_W = 5;

endpackage

// ==== src/xinmux.sv ====
`timescale 1ns/10ps
`include "versat_dp_params.svh"

module xinmux
   import versat_dp_pkg::*;
(
   input  sel_t  sel,
   input  bus_t  data_in,
   output data_t data_out
);

   // bus split into its slots
   data_t slot [`N_SLOTS];

   genvar i;

   generate
      for (i = 0; i < `N_SLOTS; i++) begin : g_slot
         assign slot[i] = data_in[i*`DATA_W +: `DATA_W];
      end
   endgenerate

   // pick the operand
   assign data_out = slot[sel];

endmodule

// ==== src/xalu.sv ====
`timescale 1ns/10ps
`include "versat_dp_params.svh"

module xalu
   import versat_dp_pkg::*;
(
   input  logic                      clk,
   input  logic                      rst,
   input  bus_t                      flow_in,
   input  logic [`ALU_CONF_BITS-1:0] conf,
   output data_t                     flow_out
);

   // unpacked configuration
   sel_t sel_a;
   sel_t sel_b;
   alu_fns_t fns;

   // mux outputs and their registered copies
   data_t op_a;
   data_t op_b;
   data_t op_a_reg;
   data_t op_b_reg;

   data_t res;

   assign sel_a = conf[`ALU_CONF_BITS-1 -: `N_W];
   assign sel_b = conf[`ALU_CONF_BITS-1-`N_W -: `N_W];
   assign fns = conf[`ALU_FNS_W-1:0];

   // operand selection from the bus
   xinmux mux_a (
      .sel      (sel_a),
      .data_in  (flow_in),
      .data_out (op_a)
   );

   xinmux mux_b (
      .sel      (sel_b),
      .data_in  (flow_in),
      .data_out (op_b)
   );

   // first stage
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         op_a_reg <= '0;
         op_b_reg <= '0;
      end else begin
         op_a_reg <= op_a;
         op_b_reg <= op_b;
      end
   end

   // sub wraps modulo 2^32
   always_comb begin
      case (fns)
         ALU_ADD:  res = op_a_reg + op_b_reg;
         ALU_SUB:  res = op_a_reg - op_b_reg;
         ALU_AND:  res = op_a_reg & op_b_reg;
         ALU_OR:   res = op_a_reg | op_b_reg;
         ALU_XOR:  res = op_a_reg ^ op_b_reg;
         ALU_PASS: res = op_a_reg;
         default:  res = op_a_reg;
      endcase
   end

   // second stage, result goes back onto bus slot 2
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         flow_out <= '0;
      end else begin
         flow_out <= res;
      end
   end

   // active config comes from xconf_reg, must be known once out of reset
   a_fns_known: assert property (@(posedge clk) disable iff (rst) !$isunknown(fns))
      else $error("xalu: function code unknown");

endmodule

// ==== src/xbs.sv ====
`timescale 1ns/10ps
`include "versat_dp_params.svh"

module xbs
   import versat_dp_pkg::*;
(
   input  logic                     clk,
   input  logic                     rst,
   input  bus_t                     flow_in,
   input  logic [`BS_CONF_BITS-1:0] conf,
   output data_t                    flow_out
);

   // unpacked configuration
   sel_t sel_data;
   sel_t sel_shift;
   bs_fns_t fns;

   // mux outputs and their registered copies
   data_t data_in;
   data_t shift;
   data_t data_in_reg;
   data_t shift_reg;

   logic [SHIFT_AMT_W-1:0] amt;
   data_t res;

   assign sel_data = conf[`BS_CONF_BITS-1 -: `N_W];
   assign sel_shift = conf[`BS_CONF_BITS-1-`N_W -: `N_W];
   assign fns = conf[`BS_FNS_W-1:0];

   xinmux mux_data (
      .sel      (sel_data),
      .data_in  (flow_in),
      .data_out (data_in)
   );

   xinmux mux_shift (
      .sel      (sel_shift),
      .data_in  (flow_in),
      .data_out (shift)
   );

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         data_in_reg <= '0;
         shift_reg <= '0;
      end else begin
         data_in_reg <= data_in;
         shift_reg <= shift;
      end
   end

   // only the low 5 bits count
   assign amt = shift_reg[SHIFT_AMT_W-1:0];

   always_comb begin
      case (fns)
         // sign fill needs a signed operand
         BS_SHR_A: res = $signed(data_in_reg) >>> amt;
         BS_SHR_L: res = data_in_reg >> amt;
         BS_SHL:   res = data_in_reg << amt;
         default:  res = data_in_reg;
      endcase
   end

   // result onto bus slot 3
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         flow_out <= '0;
      end else begin
         flow_out <= res;
      end
   end

   a_fns_known: assert property (@(posedge clk) disable iff (rst) !$isunknown(fns))
      else $error("xbs: function code unknown");

endmodule

// ==== src/xconf_reg.sv ====
`timescale 1ns/10ps
`include "versat_dp_params.svh"

module xconf_reg
   import versat_dp_pkg::*;
(
   input  logic                      clk,
   input  logic                      rst,
   input  logic                      conf_we,
   input  logic                      conf_addr,
   input  logic [`CONF_W-1:0]        conf_data,
   input  logic                      conf_update,
   output logic [`ALU_CONF_BITS-1:0] alu_conf,
   output logic [`BS_CONF_BITS-1:0]  bs_conf
);

   // shadow copies, written one unit at a time
   logic [`ALU_CONF_BITS-1:0] alu_shadow;
   logic [`BS_CONF_BITS-1:0] bs_shadow;

   logic alu_we;
   logic bs_we;

   // address decode
   assign alu_we = conf_we && (conf_addr == `CONF_ADDR_ALU);
   assign bs_we = conf_we && (conf_addr == `CONF_ADDR_BS);

   // shadow writes take the low bits of conf_data only
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         alu_shadow <= '0;
         bs_shadow <= '0;
      end else begin
         if (alu_we) begin
            alu_shadow <= conf_data[`ALU_CONF_BITS-1:0];
         end
         if (bs_we) begin
            bs_shadow <= conf_data[`BS_CONF_BITS-1:0];
         end
      end
   end

   // both units switch on the same edge
   // a write in the update cycle lands in the shadow only,
   // the active copy takes the old shadow value
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         alu_conf <= '0;
         bs_conf <= '0;
      end else if (conf_update) begin
         alu_conf <= alu_shadow;
         bs_conf <= bs_shadow;
      end
   end

   // an unknown address would corrupt a shadow silently
   a_addr_known: assert property (
      @(posedge clk) disable iff (rst) conf_we |-> !$isunknown(conf_addr)
   ) else $error("xconf_reg: conf_addr unknown during write");

endmodule

// ==== src/xdata_engine.sv ====
`timescale 1ns/10ps
`include "versat_dp_params.svh"

module xdata_engine
   import versat_dp_pkg::*;
(
   input  logic               clk,
   input  logic               rst,

   // external operands
   input  data_t              in_a,
   input  data_t              in_b,

   // configuration strobes
   input  logic               conf_we,
   input  logic               conf_addr,
   input  logic [`CONF_W-1:0] conf_data,
   input  logic               conf_update,

   // unit results
   output data_t              alu_out,
   output data_t              bs_out
);

   // active configuration per unit
   logic [`ALU_CONF_BITS-1:0] alu_conf;
   logic [`BS_CONF_BITS-1:0] bs_conf;

   // shared data bus
   bus_t bus;

   // slot order from low bits: in_a, in_b, alu, shifter
   assign bus = {bs_out, alu_out, in_b, in_a};

   xconf_reg conf_reg0 (
      .clk         (clk),
      .rst         (rst),
      .conf_we     (conf_we),
      .conf_addr   (conf_addr),
      .conf_data   (conf_data),
      .conf_update (conf_update),
      .alu_conf    (alu_conf),
      .bs_conf     (bs_conf)
   );

   // producer feeding its result back onto slot 2
   xalu alu0 (
      .clk      (clk),
      .rst      (rst),
      .flow_in  (bus),
      .conf     (alu_conf),
      .flow_out (alu_out)
   );

   // consumer feeding its result back onto slot 3
   xbs bs0 (
      .clk      (clk),
      .rst      (rst),
      .flow_in  (bus),
      .conf     (bs_conf),
      .flow_out (bs_out)
   );

endmodule

// ==== verif/tb_xdata_engine.sv ====
`timescale 1ns/10ps
`include "versat_dp_params.svh"

module tb_xdata_engine
   import versat_dp_pkg::*;
();

   // record kinds in the data file
   localparam int KIND_DEFAULT = 0;
   localparam int KIND_SETTLE = 1;
   localparam int KIND_FEEDBACK = 2;
   localparam int KIND_SHADOW = 3;

   localparam string DATA_FILE = "verif/xdata_engine_testdata.txt";

   // filler, two writes, update, then seven more cycles
   localparam int REC_CYCLES = 12;

   logic clk;
   logic rst;
   data_t in_a;
   data_t in_b;
   logic conf_we;
   logic conf_addr;
   logic [`CONF_W-1:0] conf_data;
   logic conf_update;
   data_t alu_out;
   data_t bs_out;

   // records from the data file
   int rec_kind [$];
   logic [`CONF_W-1:0] rec_alu_conf [$];
   logic [`CONF_W-1:0] rec_bs_conf [$];
   data_t rec_in_a [$];
   data_t rec_in_b [$];
   data_t rec_exp_alu [$];
   data_t rec_exp_bs [$];

   int alu_errors;
   int bs_errors;
   int cycle_count;
   int cycle_limit;
   int n_loaded;

   xdata_engine dut0 (
      .clk         (clk),
      .rst         (rst),
      .in_a        (in_a),
      .in_b        (in_b),
      .conf_we     (conf_we),
      .conf_addr   (conf_addr),
      .conf_data   (conf_data),
      .conf_update (conf_update),
      .alu_out     (alu_out),
      .bs_out      (bs_out)
   );

   always #5 clk = ~clk;

   // run limit is set from the record count once the file is loaded
   always @(posedge clk) begin
      cycle_count++;
      if (cycle_count > cycle_limit) begin
         $display("timeout: run did not finish within %0d cycles", cycle_limit);
         $display("=== FAIL ===");
         $finish;
      end
   end

   task automatic load_records(output int count);
      int fd;
      int n;
      logic [8*160-1:0] line;
      logic [7:0] kind;
      logic [`CONF_W-1:0] ac;
      logic [`CONF_W-1:0] bc;
      data_t a;
      data_t b;
      data_t ea;
      data_t eb;
      count = 0;
      fd = $fopen(DATA_FILE, "r");
      if (fd == 0) begin
         $display("could not open test data file %s", DATA_FILE);
      end else begin
         n = $fgets(line, fd);
         while (n != 0) begin
            // comment and blank lines do not scan to seven fields
            if ($sscanf(line, "%h %h %h %h %h %h %h", kind, ac, bc, a, b, ea, eb) == 7) begin
               rec_kind.push_back(int'(kind));
               rec_alu_conf.push_back(ac);
               rec_bs_conf.push_back(bc);
               rec_in_a.push_back(a);
               rec_in_b.push_back(b);
               rec_exp_alu.push_back(ea);
               rec_exp_bs.push_back(eb);
               count++;
            end
            n = $fgets(line, fd);
         end
         $fclose(fd);
      end
   endtask

   task automatic next_cycle();
      @(posedge clk);
      #1;
   endtask

   task automatic check_outputs(input int idx);
      assert (alu_out === rec_exp_alu[idx])
         else begin
            $display("FAILED at %0t: record %0d alu_out %h, expected %h",
               $time, idx, alu_out, rec_exp_alu[idx]);
            alu_errors++;
         end
      assert (bs_out === rec_exp_bs[idx])
         else begin
            $display("FAILED at %0t: record %0d bs_out %h, expected %h",
               $time, idx, bs_out, rec_exp_bs[idx]);
            bs_errors++;
         end
   endtask

   task automatic run_record(input int idx);
      int kind;
      logic [31:0] rnd;
      kind = rec_kind[idx];
      // filler cycle drives random address and data with no strobe
      next_cycle();
      rnd = $urandom;
      conf_addr = rnd[0];
      conf_data = rnd[8 +: `CONF_W];
      next_cycle();
      in_a = rec_in_a[idx];
      in_b = rec_in_b[idx];
      if (kind != KIND_DEFAULT) begin
         conf_we = 1'b1;
         conf_addr = `CONF_ADDR_ALU;
         conf_data = rec_alu_conf[idx];
      end
      next_cycle();
      if (kind != KIND_DEFAULT) begin
         conf_addr = `CONF_ADDR_BS;
         conf_data = rec_bs_conf[idx];
      end
      next_cycle();
      conf_we = 1'b0;
      // shadow-only records skip the update pulse
      if (kind != KIND_DEFAULT && kind != KIND_SHADOW) begin
         conf_update = 1'b1;
      end
      next_cycle();
      conf_update = 1'b0;
      if (kind == KIND_FEEDBACK) begin
         // two cycles past the update edge while the accumulator still moves
         next_cycle();
         next_cycle();
      end else begin
         repeat (REC_CYCLES - 5) next_cycle();
      end
      check_outputs(idx);
   endtask

   initial begin
      clk = 1'b0;
      rst = 1'b1;
      in_a = '0;
      in_b = '0;
      conf_we = 1'b0;
      conf_addr = 1'b0;
      conf_data = '0;
      conf_update = 1'b0;
      alu_errors = 0;
      bs_errors = 0;
      cycle_count = 0;
      cycle_limit = 50;
      void'($urandom(46));
      load_records(n_loaded);
      if (n_loaded == 0) begin
         $display("no test records loaded, run stopped");
         $display("=== FAIL ===");
         $finish;
      end else begin
         cycle_limit = n_loaded * REC_CYCLES + 50;
         repeat (4) @(posedge clk);
         #1;
         rst = 1'b0;
         for (int i = 0; i < n_loaded; i++) begin
            run_record(i);
         end
         $display("errors: alu_out %0d, bs_out %0d over %0d records",
            alu_errors, bs_errors, n_loaded);
         if (alu_errors + bs_errors == 0) begin
            $display("=== PASS ===");
         end else begin
            $display("=== FAIL ===");
         end
         $finish;
      end
   end

endmodule

// ==== versat_dp.f ====
+incdir+include
src/versat_dp_pkg.sv
src/xinmux.sv
src/xalu.sv
src/xbs.sv
src/xconf_reg.sv
src/xdata_engine.sv
verif/tb_xdata_engine.sv

// ==== verif/xdata_engine_testdata.txt ====
# kind alu_conf bs_conf in_a in_b exp_alu_out exp_bs_out, all hex
# kind 0 reset config, 1 update and settle, 2 check 2 cycles after update, 3 shadows only
# alu_conf = sel_a<<5 | sel_b<<3 | fns, bs_conf = sel_data<<4 | sel_shift<<2 | fns
# default config straight after reset
0 00 00 00000000 12345678 00000000 00000000
0 00 00 40000003 00000000 80000006 08000000
0 00 00 90000001 00000000 20000002 C8000000
# alu functions on in_a and in_b, shifter passes slot 0 or 1
1 08 03 00001234 00000F0F 00002143 00001234
1 08 13 FFFFFFF0 00000020 00000010 00000020
1 09 03 80000000 00000001 7FFFFFFF 80000000
1 09 13 00000005 0000000A FFFFFFFB 0000000A
1 21 13 00000003 00000010 0000000D 00000010
1 0A 03 F0F0A5A5 FF00FF00 F000A500 F0F0A5A5
1 0B 13 0F0F0000 000012F0 0F0F12F0 000012F0
1 0C 03 DEADBEEF FFFF0000 2152BEEF DEADBEEF
1 0D 13 CAFEF00D 12345678 CAFEF00D 12345678
1 0E 03 01020304 0A0B0C0D 01020304 01020304
1 0F 13 55AA55AA 00000001 55AA55AA 00000001
# shifter fed from the alu slot
1 08 26 00000100 00000004 00000104 00001040
1 09 25 00000000 00000008 FFFFFFF8 00FFFFFF
1 0C 24 80000000 00000010 80000010 FFFF8000
1 0A 0A 000000FF 00000003 00000003 000007F8
# shifter functions, data in_a, amount in_b, alu passes in_a
1 0D 04 F0000000 00000004 F0000000 FF000000
1 0D 04 80000010 00000024 80000010 F8000001
1 0D 04 7FFFFFFF 0000001F 7FFFFFFF 00000000
1 0D 05 F0000000 00000004 F0000000 0F000000
1 0D 05 80000000 FFFFFFE8 80000000 00800000
1 0D 06 00000001 0000001F 00000001 80000000
1 0D 06 12345678 00000023 12345678 91A2B3C0
# previous alu config must stay pass slot 0 for the feedback record
1 0D 07 A5A5A5A5 00000003 A5A5A5A5 A5A5A5A5
# alu adds its own slot to in_a
2 40 03 00000007 00000100 0000000E 00000007
# back to a chain without feedback
1 08 25 11111111 22222222 33333333 0CCCCCCC
# new shadows without update, outputs hold
3 09 07 11111111 22222222 33333333 0CCCCCCC
1 09 07 11111111 22222222 EEEEEEEF 11111111
